/* udp_arb_mux.f */
logic/udp_mux_pkg.sv
logic/udp_rr_arbiter.sv
logic/udp_hdr_select.sv
logic/udp_payload_path.sv
logic/udp_arb_mux.sv
testbench/udp_arb_mux_props.sv
testbench/udp_arb_mux_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the UDP multiplexer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module udp_arb_mux_tb -f udp_arb_mux.f -o udp_sim

output=$(./obj_dir/udp_sim) || true
echo "$output"

if grep -qx "TEST OK" <<< "$output"; then
    exit 0
fi
exit 1

/* testbench/udp_arb_mux_tb.sv */
/*
 * Testbench for the UDP multiplexer.
 * A table of rounds says which sources send a frame, with header word and
 * payload length. Each source runs as its own process, the sink stalls at
 * random, and a checker compares headers and bytes in round-robin order.
 */

`timescale 1ns/1ns
`default_nettype none

module udp_arb_mux_tb import udp_mux_pkg::*; ();

    localparam int num_rounds = 6;
    localparam int max_wait   = 2000;

    logic clk = 1'b0;
    logic rst;
    logic [src_count-1:0]   hdr_valid;
    wire  [src_count-1:0]   hdr_ready;
    logic [ip_addr_w-1:0]   ip_source_ip [src_count];
    logic [ip_addr_w-1:0]   ip_dest_ip [src_count];
    logic [udp_field_w-1:0] udp_source_port [src_count];
    logic [udp_field_w-1:0] udp_dest_port [src_count];
    logic [udp_field_w-1:0] udp_length [src_count];
    logic [udp_field_w-1:0] udp_checksum [src_count];
    logic [data_w-1:0]      tdata [src_count];
    logic [src_count-1:0]   tvalid;
    wire  [src_count-1:0]   tready;
    logic [src_count-1:0]   tlast;
    logic [user_w-1:0]      tuser [src_count];
    wire                    out_hdr_valid;
    logic                   out_hdr_ready;
    wire  [ip_addr_w-1:0]   out_ip_source_ip;
    wire  [ip_addr_w-1:0]   out_ip_dest_ip;
    wire  [udp_field_w-1:0] out_udp_source_port;
    wire  [udp_field_w-1:0] out_udp_dest_port;
    wire  [udp_field_w-1:0] out_udp_length;
    wire  [udp_field_w-1:0] out_udp_checksum;
    wire  [data_w-1:0]      out_tdata;
    wire                    out_tvalid;
    logic                   out_tready;
    wire                    out_tlast;
    wire  [user_w-1:0]      out_tuser;

    // round table
    logic [src_count-1:0] round_send [num_rounds];
    int                   round_len [num_rounds][src_count];
    logic [31:0]          round_ip [num_rounds][src_count];

    // expected frame order and checker position
    int frame_src[$];
    int frame_round[$];
    int hdr_pos = 0;
    int pay_pos = 0;
    int byte_pos = 0;
    int errors = 0;
    int timeouts = 0;
    logic sink_on = 1'b0;
    logic [31:0] lfsr;

    udp_arb_mux dut_i (.*);

    bind udp_arb_mux udp_arb_mux_props props_i (
        .clk(clk), .rst(rst), .grant(grant), .grant_valid(grant_valid),
        .frame_done(frame_done), .hdr_ready(hdr_ready),
        .out_tvalid(out_tvalid), .out_tready(out_tready), .out_tdata(out_tdata),
        .out_tlast(out_tlast), .out_tuser(out_tuser)
    );

    always #5 clk = ~clk;

    function automatic void load_table();
        round_send = '{4'b1111, 4'b0110, 4'b1001, 4'b0001, 4'b1110, 4'b1111};
        round_len[0] = '{3, 1, 5, 2};
        round_len[1] = '{1, 4, 2, 6};
        round_len[2] = '{2, 3, 1, 4};
        round_len[3] = '{6, 2, 2, 1};
        round_len[4] = '{1, 2, 3, 4};
        round_len[5] = '{5, 1, 1, 3};
        round_ip[0] = '{32'hc0a8_0101, 32'hc0a8_0102, 32'hc0a8_0103, 32'hc0a8_0104};
        round_ip[1] = '{32'h0a00_1001, 32'h0a00_1002, 32'h0a00_1003, 32'h0a00_1004};
        round_ip[2] = '{32'hac10_2a01, 32'hac10_2a02, 32'hac10_2a03, 32'hac10_2a04};
        round_ip[3] = '{32'h7f00_0001, 32'h7f00_0002, 32'h7f00_0003, 32'h7f00_0004};
        round_ip[4] = '{32'hdead_0011, 32'hdead_0022, 32'hdead_0033, 32'hdead_0044};
        round_ip[5] = '{32'h5a5a_a501, 32'h5a5a_a502, 32'h5a5a_a503, 32'h5a5a_a504};
    endfunction

    // src ip, dest ip, ports, length, checksum, all from the table word
    function automatic logic [127:0] table_header(input int r, input int s);
        logic [31:0] w;
        w = round_ip[r][s];
        return {w, {w[15:0], w[31:16]} ^ 32'h0a00_0000, w[15:0], w[31:16] ^ 16'h1234,
                16'(8 + round_len[r][s]), w[31:16] ^ w[15:0]};
    endfunction

    function automatic logic [data_w-1:0] payload_byte(input int s, input int r, input int i);
        return data_w'((s << 6) + (r << 3) + i * 5 + 1);
    endfunction

    function automatic logic [user_w-1:0] payload_user(input int s, input int i);
        return user_w'((s + i) % 2);
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic send_frame(input int s, input int r);
        logic [127:0] h;
        int count;
        logic taken;
        if (!round_send[r][s]) return;
        h = table_header(r, s);
        @(posedge clk);
        ip_source_ip[s]    <= h[127:96];
        ip_dest_ip[s]      <= h[95:64];
        udp_source_port[s] <= h[63:48];
        udp_dest_port[s]   <= h[47:32];
        udp_length[s]      <= h[31:16];
        udp_checksum[s]    <= h[15:0];
        hdr_valid[s]       <= 1'b1;
        count = 0;
        taken = 1'b0;
        while (!taken && count < max_wait) begin
            @(posedge clk);
            taken = hdr_ready[s];
            count++;
        end
        hdr_valid[s] <= 1'b0;
        if (!taken) begin
            timeouts++;
            $display("source %0d never got its header taken in round %0d", s, r);
            return;
        end
        for (int i = 0; i < round_len[r][s]; i++) begin
            tdata[s]  <= payload_byte(s, r, i);
            tuser[s]  <= payload_user(s, i);
            tlast[s]  <= (i == round_len[r][s] - 1);
            tvalid[s] <= 1'b1;
            count = 0;
            taken = 1'b0;
            while (!taken && count < max_wait) begin
                @(posedge clk);
                taken = tready[s];
                count++;
            end
            if (!taken) begin
                timeouts++;
                $display("source %0d payload byte %0d was never accepted", s, i);
                break;
            end
        end
        tvalid[s] <= 1'b0;
        tlast[s]  <= 1'b0;
    endtask

    // sink with random back-pressure, ready about three cycles in four
    initial begin
        logic first_bit;
        out_tready    <= 1'b0;
        out_hdr_ready <= 1'b0;
        lfsr = 32'hb959_af45;
        forever begin
            @(posedge clk);
            if (sink_on) begin
                lfsr = lfsr_step(lfsr);
                first_bit = lfsr[0];
                lfsr = lfsr_step(lfsr);
                out_tready <= first_bit | lfsr[0];
                lfsr = lfsr_step(lfsr);
                first_bit = lfsr[0];
                lfsr = lfsr_step(lfsr);
                out_hdr_ready <= first_bit | lfsr[0];
            end
        end
    end

    always @(posedge clk) begin
        int s;
        int r;
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            if (hdr_pos >= frame_src.size()) begin
                errors++;
                $display("ERROR at %0t: header with no frame expected", $time);
            end else begin
                check_value("output header",
                            {out_ip_source_ip, out_ip_dest_ip, out_udp_source_port,
                             out_udp_dest_port, out_udp_length, out_udp_checksum},
                            table_header(frame_round[hdr_pos], frame_src[hdr_pos]));
                hdr_pos++;
            end
        end
        if (!rst && out_tvalid && out_tready) begin
            if (pay_pos >= frame_src.size()) begin
                errors++;
                $display("ERROR at %0t: payload byte with no frame expected", $time);
            end else begin
                s = frame_src[pay_pos];
                r = frame_round[pay_pos];
                check_value("tdata", 128'(out_tdata), 128'(payload_byte(s, r, byte_pos)));
                check_value("tuser", 128'(out_tuser), 128'(payload_user(s, byte_pos)));
                check_value("tlast", 128'(out_tlast),
                            128'(byte_pos == round_len[r][s] - 1));
                byte_pos++;
                if (byte_pos == round_len[r][s]) begin
                    pay_pos++;
                    byte_pos = 0;
                end
            end
        end
    end

    initial begin
        int last_grant;
        int next_last;
        int idx;
        int count;
        load_table();
        rst       <= 1'b1;
        hdr_valid <= '0;
        tvalid    <= '0;
        tlast     <= '0;
        for (int s = 0; s < src_count; s++) begin
            ip_source_ip[s]    <= '0;
            ip_dest_ip[s]      <= '0;
            udp_source_port[s] <= '0;
            udp_dest_port[s]   <= '0;
            udp_length[s]      <= '0;
            udp_checksum[s]    <= '0;
            tdata[s]           <= '0;
            tuser[s]           <= '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("out_hdr_valid after reset", 128'(out_hdr_valid), '0);
        check_value("out_tvalid after reset", 128'(out_tvalid), '0);
        check_value("hdr_ready after reset", 128'(hdr_ready), '0);
        check_value("tready after reset", 128'(tready), '0);
        sink_on <= 1'b1;

        last_grant = src_count - 1;
        for (int r = 0; r < num_rounds; r++) begin
            // round robin from the source after the last grantee
            next_last = last_grant;
            for (int k = 1; k <= src_count; k++) begin
                idx = (last_grant + k) % src_count;
                if (round_send[r][idx]) begin
                    frame_src.push_back(idx);
                    frame_round.push_back(r);
                    next_last = idx;
                end
            end
            last_grant = next_last;
            fork
                send_frame(0, r);
                send_frame(1, r);
                send_frame(2, r);
                send_frame(3, r);
            join
            count = 0;
            while ((hdr_pos < frame_src.size() || pay_pos < frame_src.size()) &&
                   count < max_wait) begin
                @(posedge clk);
                count++;
            end
            if (hdr_pos < frame_src.size() || pay_pos < frame_src.size()) begin
                timeouts++;
                $display("round %0d frames never all reached the sink", r);
            end
        end

        $display("mismatches: %0d, timeouts: %0d, frames: %0d", errors, timeouts,
                 frame_src.size());
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/udp_arb_mux_props.sv */
/*
 * Handshake properties for the UDP multiplexer, bound to the top level.
 * Checks the arbiter grant, the per-source header ready pulse and the
 * output payload while the sink stalls.
 */

`timescale 1ns/1ns
`default_nettype none

module udp_arb_mux_props import udp_mux_pkg::*; (
    input wire                 clk,
    input wire                 rst,
    input wire [src_count-1:0] grant,
    input wire                 grant_valid,
    input wire                 frame_done,
    input wire [src_count-1:0] hdr_ready,
    input wire                 out_tvalid,
    input wire                 out_tready,
    input wire [data_w-1:0]    out_tdata,
    input wire                 out_tlast,
    input wire [user_w-1:0]    out_tuser
);

    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && (grant_valid == (grant != '0)))
        else $error("arbiter grant is not one-hot or disagrees with grant_valid");

    // the grant only moves once the frame has ended
    grant_held: assert property (@(posedge clk) disable iff (rst)
        grant_valid && !frame_done |=> grant_valid && $stable(grant))
        else $error("arbiter grant changed before the frame ended");

    // header ready only reaches the source that owns the output
    hdr_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hdr_ready) && ((hdr_ready & ~grant) == '0))
        else $error("hdr_ready pulsed to a source without the grant");

    // a stalled byte must sit still until the sink takes it
    out_stable: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
                                      $stable(out_tlast) && $stable(out_tuser))
        else $error("output payload changed while stalled");

endmodule

`default_nettype wire

/* logic/udp_arb_mux.sv */
/*
 * Arbitrated multiplexer for UDP frames from four sources.
 * Connects the round-robin arbiter, the header register and the payload
 * skid buffer. A source keeps the output from its header until its last
 * payload byte is accepted.
 */

`timescale 1ns/1ns
`default_nettype none

module udp_arb_mux import udp_mux_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,

    // source headers
    input  wire  [src_count-1:0]   hdr_valid,
    output wire  [src_count-1:0]   hdr_ready,
    input  wire  [ip_addr_w-1:0]   ip_source_ip [src_count],
    input  wire  [ip_addr_w-1:0]   ip_dest_ip [src_count],
    input  wire  [udp_field_w-1:0] udp_source_port [src_count],
    input  wire  [udp_field_w-1:0] udp_dest_port [src_count],
    input  wire  [udp_field_w-1:0] udp_length [src_count],
    input  wire  [udp_field_w-1:0] udp_checksum [src_count],

    // source payloads
    input  wire  [data_w-1:0]      tdata [src_count],
    input  wire  [src_count-1:0]   tvalid,
    output wire  [src_count-1:0]   tready,
    input  wire  [src_count-1:0]   tlast,
    input  wire  [user_w-1:0]      tuser [src_count],

    // output header
    output wire                    out_hdr_valid,
    input  wire                    out_hdr_ready,
    output wire  [ip_addr_w-1:0]   out_ip_source_ip,
    output wire  [ip_addr_w-1:0]   out_ip_dest_ip,
    output wire  [udp_field_w-1:0] out_udp_source_port,
    output wire  [udp_field_w-1:0] out_udp_dest_port,
    output wire  [udp_field_w-1:0] out_udp_length,
    output wire  [udp_field_w-1:0] out_udp_checksum,

    // output payload
    output wire  [data_w-1:0]      out_tdata,
    output wire                    out_tvalid,
    input  wire                    out_tready,
    output wire                    out_tlast,
    output wire  [user_w-1:0]      out_tuser
);

    wire [src_count-1:0] request;
    wire [src_count-1:0] grant;
    wire                 grant_valid;
    wire [src_idx_w-1:0] grant_idx;
    wire                 frame_done;

    udp_rr_arbiter arb_i (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (frame_done),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    udp_hdr_select hdr_i (
        .clk                 (clk),
        .rst                 (rst),
        .hdr_valid           (hdr_valid),
        .ip_source_ip        (ip_source_ip),
        .ip_dest_ip          (ip_dest_ip),
        .udp_source_port     (udp_source_port),
        .udp_dest_port       (udp_dest_port),
        .udp_length          (udp_length),
        .udp_checksum        (udp_checksum),
        .grant               (grant),
        .grant_valid         (grant_valid),
        .grant_idx           (grant_idx),
        .frame_done          (frame_done),
        .out_hdr_ready       (out_hdr_ready),
        .hdr_ready           (hdr_ready),
        .request             (request),
        .out_hdr_valid       (out_hdr_valid),
        .out_ip_source_ip    (out_ip_source_ip),
        .out_ip_dest_ip      (out_ip_dest_ip),
        .out_udp_source_port (out_udp_source_port),
        .out_udp_dest_port   (out_udp_dest_port),
        .out_udp_length      (out_udp_length),
        .out_udp_checksum    (out_udp_checksum)
    );

    udp_payload_path pay_i (
        .clk         (clk),
        .rst         (rst),
        .tdata       (tdata),
        .tvalid      (tvalid),
        .tlast       (tlast),
        .tuser       (tuser),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .out_tready  (out_tready),
        .tready      (tready),
        .frame_done  (frame_done),
        .out_tdata   (out_tdata),
        .out_tvalid  (out_tvalid),
        .out_tlast   (out_tlast),
        .out_tuser   (out_tuser)
    );

endmodule

`default_nettype wire

/* logic/udp_payload_path.sv */
/*
 * Payload path of the UDP multiplexer.
 * Selects the granted source's byte stream and feeds a two-entry skid
 * buffer (output entry plus temp entry), so the registered ready to the
 * source can lag the sink by a cycle without losing a byte. Flags
 * frame_done when the accepted byte carries tlast.
 */

`timescale 1ns/1ns
`default_nettype none

module udp_payload_path import udp_mux_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  [data_w-1:0]    tdata [src_count],
    input  wire  [src_count-1:0] tvalid,
    input  wire  [src_count-1:0] tlast,
    input  wire  [user_w-1:0]    tuser [src_count],
    input  wire                  grant_valid,
    input  wire  [src_idx_w-1:0] grant_idx,
    input  wire                  out_tready,
    output logic [src_count-1:0] tready,
    output logic                 frame_done,
    output logic [data_w-1:0]    out_tdata,
    output logic                 out_tvalid,
    output logic                 out_tlast,
    output logic [user_w-1:0]    out_tuser
);

    // granted stream
    logic [data_w-1:0] cur_tdata;
    logic              cur_tvalid;
    logic              cur_tlast;
    logic [user_w-1:0] cur_tuser;

    logic              tready_int;
    logic              accept;

    // temp entry of the skid buffer
    logic [data_w-1:0] temp_tdata;
    logic              temp_tvalid;
    logic              temp_tlast;
    logic [user_w-1:0] temp_tuser;

    logic out_tvalid_next;
    logic temp_tvalid_next;
    logic store_to_out;
    logic store_to_temp;
    logic temp_to_out;

    assign cur_tdata  = tdata[grant_idx];
    assign cur_tvalid = tvalid[grant_idx];
    assign cur_tlast  = tlast[grant_idx];
    assign cur_tuser  = tuser[grant_idx];

    assign accept     = cur_tvalid && tready_int;
    assign frame_done = accept && cur_tlast;

    // ready only ever reaches the granted source
    always_comb begin
        for (int i = 0; i < src_count; i++) begin
            tready[i] = tready_int && (grant_idx == src_idx_w'(i));
        end
    end

    always_comb begin
        out_tvalid_next  = out_tvalid;
        temp_tvalid_next = temp_tvalid;
        store_to_out     = 1'b0;
        store_to_temp    = 1'b0;
        temp_to_out      = 1'b0;

        if (tready_int) begin
            if (out_tready || !out_tvalid) begin
                out_tvalid_next = cur_tvalid;
                store_to_out    = 1'b1;
            end else begin
                // sink stalled after ready went out, park the byte
                temp_tvalid_next = cur_tvalid;
                store_to_temp    = 1'b1;
            end
        end else if (out_tready) begin
            out_tvalid_next  = temp_tvalid;
            temp_tvalid_next = 1'b0;
            temp_to_out      = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tready_int  <= 1'b0;
            out_tvalid  <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            // no ready in the gap while the grant is being released
            tready_int  <= grant_valid && !frame_done &&
                           (out_tready || (!out_tvalid && !temp_tvalid));
            out_tvalid  <= out_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_to_out) begin
            out_tdata <= cur_tdata;
            out_tlast <= cur_tlast;
            out_tuser <= cur_tuser;
        end else if (temp_to_out) begin
            out_tdata <= temp_tdata;
            out_tlast <= temp_tlast;
            out_tuser <= temp_tuser;
        end

        if (store_to_temp) begin
            temp_tdata <= cur_tdata;
            temp_tlast <= cur_tlast;
            temp_tuser <= cur_tuser;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_hdr_select.sv */
/*
 * Frame tracking and output header register.
 * Forms the arbiter request from the source header valids, and when a
 * frame starts it copies the granted header into the output register and
 * pulses that source's hdr_ready for one cycle. The frame ends on
 * frame_done from the payload path.
 */

`timescale 1ns/1ns
`default_nettype none

module udp_hdr_select import udp_mux_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire  [src_count-1:0]   hdr_valid,
    input  wire  [ip_addr_w-1:0]   ip_source_ip [src_count],
    input  wire  [ip_addr_w-1:0]   ip_dest_ip [src_count],
    input  wire  [udp_field_w-1:0] udp_source_port [src_count],
    input  wire  [udp_field_w-1:0] udp_dest_port [src_count],
    input  wire  [udp_field_w-1:0] udp_length [src_count],
    input  wire  [udp_field_w-1:0] udp_checksum [src_count],
    input  wire  [src_count-1:0]   grant,
    input  wire                    grant_valid,
    input  wire  [src_idx_w-1:0]   grant_idx,
    input  wire                    frame_done,
    input  wire                    out_hdr_ready,
    output logic [src_count-1:0]   hdr_ready,
    output logic [src_count-1:0]   request,
    output logic                   out_hdr_valid,
    output logic [ip_addr_w-1:0]   out_ip_source_ip,
    output logic [ip_addr_w-1:0]   out_ip_dest_ip,
    output logic [udp_field_w-1:0] out_udp_source_port,
    output logic [udp_field_w-1:0] out_udp_dest_port,
    output logic [udp_field_w-1:0] out_udp_length,
    output logic [udp_field_w-1:0] out_udp_checksum
);

    frame_state_t frame_state;
    logic         frame_start;

    // the granted source is not asking again while it owns the output
    assign request = hdr_valid & ~grant;

    // new header only once the output register is free or draining
    assign frame_start = (frame_state == frame_idle) && grant_valid &&
                         (out_hdr_ready || !out_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_state   <= frame_idle;
            hdr_ready     <= '0;
            out_hdr_valid <= 1'b0;
        end else begin
            hdr_ready <= '0;
            if (frame_start) begin
                frame_state   <= frame_active;
                hdr_ready     <= grant;
                out_hdr_valid <= 1'b1;
            end else begin
                if (frame_done) begin
                    frame_state <= frame_idle;
                end
                if (out_hdr_ready) begin
                    out_hdr_valid <= 1'b0;
                end
            end
        end
    end

    // header fields of the granted source
    always_ff @(posedge clk) begin
        if (frame_start) begin
            out_ip_source_ip    <= ip_source_ip[grant_idx];
            out_ip_dest_ip      <= ip_dest_ip[grant_idx];
            out_udp_source_port <= udp_source_port[grant_idx];
            out_udp_dest_port   <= udp_dest_port[grant_idx];
            out_udp_length      <= udp_length[grant_idx];
            out_udp_checksum    <= udp_checksum[grant_idx];
        end
    end

endmodule

`default_nettype wire

/* logic/udp_rr_arbiter.sv */
/*
 * Round-robin arbiter for the UDP multiplexer.
 * A registered one-hot grant is issued to the first requester after the
 * previous grantee, wrapping around. The grant is held until acknowledge
 * and drops on the following cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module udp_rr_arbiter import udp_mux_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  [src_count-1:0] request,
    input  wire                  acknowledge,
    output logic [src_count-1:0] grant,
    output logic                 grant_valid,
    output logic [src_idx_w-1:0] grant_idx
);

    // sources above the last grantee get first pick
    logic [src_count-1:0] mask;
    logic [src_count-1:0] masked_req;
    logic [src_count-1:0] pick_onehot;
    logic [src_count-1:0] pick_mask;
    logic [src_idx_w-1:0] pick_idx;
    logic                 pick_valid;

    always_comb begin
        masked_req = request & mask;
        pick_valid = |request;
        pick_idx   = '0;

        // scan downwards so the lowest eligible index is left standing
        for (int i = src_count - 1; i >= 0; i--) begin
            if (masked_req != '0) begin
                if (masked_req[i]) begin
                    pick_idx = src_idx_w'(i);
                end
            end else if (request[i]) begin
                pick_idx = src_idx_w'(i);
            end
        end

        for (int i = 0; i < src_count; i++) begin
            pick_onehot[i] = (pick_idx == src_idx_w'(i));
            pick_mask[i]   = (i > int'(pick_idx));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            mask        <= '0;
        end else if (grant_valid) begin
            // blocking grant, released only by acknowledge
            if (acknowledge) begin
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end else if (pick_valid) begin
            grant       <= pick_onehot;
            grant_valid <= 1'b1;
            grant_idx   <= pick_idx;
            mask        <= pick_mask;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_mux_pkg.sv */
/*
 * Shared constants and types for the four-source UDP frame multiplexer.
 * Every block imports this package for the source count, the field widths
 * and the frame state encoding.
 */

`default_nettype none

package udp_mux_pkg;

    // sources competing for the output
    localparam int src_count = 4;
    localparam int src_idx_w = $clog2(src_count);

    // payload stream
    localparam int data_w = 8;
    localparam int user_w = 1;

    // header fields kept from the IP and UDP headers
    localparam int ip_addr_w   = 32;
    localparam int udp_field_w = 16;

    // whether a frame currently owns the output
    typedef enum logic {
        frame_idle   = 1'b0,
        frame_active = 1'b1
    } frame_state_t;

endpackage

`default_nettype wire
